/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Data bus width in bits.
  localparam int data_width = 32;

  // Byte address width.
  localparam int addr_width = 32;

  // One strobe bit per byte lane.
  localparam int strb_width = data_width / 8;

  //////////////////////////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_t;

  //////////////////////////////////////////////////////////////////////
  // Memory defaults
  //////////////////////////////////////////////////////////////////////

  localparam int default_mem_words = 1024;

  // Wait cycles before the memory answers. Must be at least one.
  localparam int default_latency = 2;

endpackage

`default_nettype wire

/* lsu_lane_steer.sv */
`default_nettype none

module lsu_lane_steer (
  input  logic [1:0]                    addr_low,
  input  lsu_pkg::size_t                size,
  input  logic                          sext,
  input  logic [lsu_pkg::data_width-1:0] wsrc,
  input  logic [lsu_pkg::data_width-1:0] rdata,
  output logic [lsu_pkg::data_width-1:0] wdata,
  output logic [lsu_pkg::strb_width-1:0] wstrb,
  output logic [lsu_pkg::data_width-1:0] load_value
);

  // Bit offset of the addressed byte lane.
  logic [4:0]                     shift;
  logic [lsu_pkg::data_width-1:0] shifted;

  assign shift   = {addr_low, 3'b000};
  assign shifted = rdata >> shift;

  // Store side.
  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        wdata = {{(lsu_pkg::data_width - 8){1'b0}}, wsrc[7:0]} << shift;
        wstrb = 4'b0001 << addr_low;
      end
      lsu_pkg::size_half: begin
        wdata = {{(lsu_pkg::data_width - 16){1'b0}}, wsrc[15:0]} << shift;
        wstrb = 4'b0011 << addr_low;
      end
      default: begin
        wdata = wsrc;
        wstrb = '1;
      end
    endcase
  end

  // Load side. The sign comes from the selected data.
  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        load_value = {{(lsu_pkg::data_width - 8){sext & shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::size_half: begin
        load_value = {{(lsu_pkg::data_width - 16){sext & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        load_value = rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

/* lsu_axi.sv */
`default_nettype none

module lsu_axi (
  input  logic                           clock,
  input  logic                           reset,
  // Core side.
  input  logic                           ren,
  input  logic                           wen,
  input  logic [lsu_pkg::addr_width-1:0] addr,
  input  lsu_pkg::size_t                 size,
  input  logic                           sext,
  input  logic [lsu_pkg::data_width-1:0] wsrc,
  output logic [lsu_pkg::data_width-1:0] mem_rdata,
  output logic                           read_done,
  output logic                           write_done,
  // Read channels.
  output logic [lsu_pkg::addr_width-1:0] araddr,
  output logic                           arvalid,
  input  logic                           arready,
  input  logic [lsu_pkg::data_width-1:0] rdata,
  input  logic                           rvalid,
  output logic                           rready,
  // Write channels.
  output logic [lsu_pkg::addr_width-1:0] awaddr,
  output logic                           awvalid,
  input  logic                           awready,
  output logic [lsu_pkg::data_width-1:0] wdata,
  output logic [lsu_pkg::strb_width-1:0] wstrb,
  output logic                           wvalid,
  input  logic                           wready,
  input  logic                           bvalid,
  output logic                           bready
);

  typedef enum logic [2:0] {
    st_idle,
    st_read_addr,
    st_read_data,
    st_write_addr,
    st_write_data,
    st_write_resp,
    st_done
  } state_t;

  state_t                         state;
  logic                           write_op;
  logic [lsu_pkg::data_width-1:0] load_value;

  lsu_lane_steer u_lsu_lane_steer (
    .addr_low   (addr[1:0]),
    .size       (size),
    .sext       (sext),
    .wsrc       (wsrc),
    .rdata      (rdata),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .load_value (load_value)
  );

  // The bus sees word addresses. Lanes come from the strobes.
  assign araddr = {addr[lsu_pkg::addr_width-1:2], 2'b00};
  assign awaddr = {addr[lsu_pkg::addr_width-1:2], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= st_idle;
      write_op <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // Write wins when both strobes arrive together.
          if (wen) begin
            state    <= st_write_addr;
            write_op <= 1'b1;
          end else if (ren) begin
            state    <= st_read_addr;
            write_op <= 1'b0;
          end
        end
        st_read_addr:  if (arready) state <= st_read_data;
        st_read_data:  if (rvalid) state <= st_done;
        st_write_addr: if (awready) state <= st_write_data;
        st_write_data: if (wready) state <= st_write_resp;
        st_write_resp: if (bvalid) state <= st_done;
        default:       state <= st_idle;
      endcase
    end
  end

  // Each handshake signal is live in its own phase only.
  assign arvalid = (state == st_read_addr);
  assign rready  = (state == st_read_data);
  assign awvalid = (state == st_write_addr);
  assign wvalid  = (state == st_write_data);
  assign bready  = (state == st_write_resp);

  assign read_done  = (state == st_done) && !write_op;
  assign write_done = (state == st_done) && write_op;

  // Load result is held until the next load completes.
  always_ff @(posedge clock) begin
    if (rready && rvalid) begin
      mem_rdata <= load_value;
    end
  end

endmodule

`default_nettype wire

/* axi_lite_ram.sv */
`default_nettype none

module axi_lite_ram #(
  parameter int mem_words = lsu_pkg::default_mem_words,
  parameter int latency   = lsu_pkg::default_latency
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [lsu_pkg::addr_width-1:0] araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [lsu_pkg::data_width-1:0] rdata,
  output logic                           rvalid,
  input  logic                           rready,
  input  logic [lsu_pkg::addr_width-1:0] awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [lsu_pkg::data_width-1:0] wdata,
  input  logic [lsu_pkg::strb_width-1:0] wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic                           bvalid,
  input  logic                           bready
);

  localparam int index_width = $clog2(mem_words);
  localparam int count_width = $clog2(latency + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_read_wait,
    st_read_data,
    st_write_data,
    st_write_resp
  } state_t;

  state_t                         state;
  logic [count_width-1:0]         count;
  logic                           count_done;
  logic [index_width-1:0]         read_index;
  logic [index_width-1:0]         aw_index;
  logic [index_width-1:0]         write_index;
  logic                           ar_fire;
  logic                           aw_fire;
  logic                           w_fire;
  logic [lsu_pkg::data_width-1:0] mem [mem_words];

  assign ar_fire    = arvalid && arready;
  assign aw_fire    = awvalid && awready;
  assign w_fire     = wvalid && wready;
  assign count_done = (count == count_width'(latency - 1));

  // Word index wraps at the memory depth.
  assign read_index = index_width'(araddr[lsu_pkg::addr_width-1:2] % mem_words);
  assign aw_index   = index_width'(awaddr[lsu_pkg::addr_width-1:2] % mem_words);

  //////////////////////////////////////////////////////////////////////
  // Handshake timing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= st_idle;
      count   <= '0;
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      rvalid  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      // Ready pulses last one cycle.
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      case (state)
        st_idle: begin
          if (aw_fire) begin
            state <= st_write_data;
            count <= '0;
          end else if (ar_fire) begin
            // The transfer cycle counts as the first wait cycle.
            if (latency == 1) begin
              rvalid <= 1'b1;
              state  <= st_read_data;
            end else begin
              count <= count_width'(1);
              state <= st_read_wait;
            end
          end else if (awvalid || arvalid) begin
            if (count_done) begin
              awready <= awvalid;
              arready <= !awvalid;
              count   <= '0;
            end else begin
              count <= count + 1'b1;
            end
          end
        end
        st_read_wait: begin
          if (count_done) begin
            rvalid <= 1'b1;
            count  <= '0;
            state  <= st_read_data;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_read_data: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= st_idle;
          end
        end
        st_write_data: begin
          if (w_fire) begin
            bvalid <= 1'b1;
            count  <= '0;
            state  <= st_write_resp;
          end else if (wvalid) begin
            if (count_done) begin
              wready <= 1'b1;
              count  <= '0;
            end else begin
              count <= count + 1'b1;
            end
          end
        end
        st_write_resp: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Storage. Read data is sampled at the address transfer.
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= mem[read_index];
    end
    if (aw_fire) begin
      write_index <= aw_index;
    end
    if (w_fire) begin
      for (int i = 0; i < lsu_pkg::strb_width; i++) begin
        if (wstrb[i]) begin
          mem[write_index][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* lsu_subsystem.sv */
`default_nettype none

module lsu_subsystem #(
  parameter int mem_words = lsu_pkg::default_mem_words,
  parameter int latency   = lsu_pkg::default_latency
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           ren,
  input  logic                           wen,
  input  logic [lsu_pkg::addr_width-1:0] addr,
  input  lsu_pkg::size_t                 size,
  input  logic                           sext,
  input  logic [lsu_pkg::data_width-1:0] wsrc,
  output logic [lsu_pkg::data_width-1:0] mem_rdata,
  output logic                           read_done,
  output logic                           write_done
);

  // Bus between the LSU and the memory.
  logic [lsu_pkg::addr_width-1:0] araddr;
  logic                           arvalid;
  logic                           arready;
  logic [lsu_pkg::data_width-1:0] rdata;
  logic                           rvalid;
  logic                           rready;
  logic [lsu_pkg::addr_width-1:0] awaddr;
  logic                           awvalid;
  logic                           awready;
  logic [lsu_pkg::data_width-1:0] wdata;
  logic [lsu_pkg::strb_width-1:0] wstrb;
  logic                           wvalid;
  logic                           wready;
  logic                           bvalid;
  logic                           bready;

  lsu_axi u_lsu_axi (
    .clock      (clock),
    .reset      (reset),
    .ren        (ren),
    .wen        (wen),
    .addr       (addr),
    .size       (size),
    .sext       (sext),
    .wsrc       (wsrc),
    .mem_rdata  (mem_rdata),
    .read_done  (read_done),
    .write_done (write_done),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  axi_lite_ram #(
    .mem_words (mem_words),
    .latency   (latency)
  ) u_axi_lite_ram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

`default_nettype wire

/* lsu_chk.sv */
`default_nettype none

module lsu_chk (
  input wire logic        clock,
  input wire logic        reset,
  input wire logic [31:0] araddr,
  input wire logic        arvalid,
  input wire logic        arready,
  input wire logic        rvalid,
  input wire logic        rready,
  input wire logic [31:0] awaddr,
  input wire logic        awvalid,
  input wire logic        awready,
  input wire logic        wvalid,
  input wire logic        wready,
  input wire logic        bvalid,
  input wire logic        bready,
  input wire logic        read_done,
  input wire logic        write_done
);

  timeunit 1ns;
  timeprecision 100ps;

  // One address channel at a time.
  assert property (@(posedge clock) disable iff (reset) !(arvalid && awvalid))
    else $error("arvalid and awvalid high together");

  //////////////////////////////////////////////////////////////////////
  // Valid holds until its ready
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr changed before arready");
  assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid or awaddr changed before awready");
  assert property (@(posedge clock) disable iff (reset) wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before wready");
  assert property (@(posedge clock) disable iff (reset) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");
  assert property (@(posedge clock) disable iff (reset) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Done pulses.
  assert property (@(posedge clock) disable iff (reset) read_done |=> !read_done)
    else $error("read_done longer than one cycle");
  assert property (@(posedge clock) disable iff (reset) write_done |=> !write_done)
    else $error("write_done longer than one cycle");
  assert property (@(posedge clock) disable iff (reset) !(read_done && write_done))
    else $error("read_done and write_done high together");

endmodule

bind lsu_axi lsu_chk u_lsu_chk (
  .clock      (clock),
  .reset      (reset),
  .araddr     (araddr),
  .arvalid    (arvalid),
  .arready    (arready),
  .rvalid     (rvalid),
  .rready     (rready),
  .awaddr     (awaddr),
  .awvalid    (awvalid),
  .awready    (awready),
  .wvalid     (wvalid),
  .wready     (wready),
  .bvalid     (bvalid),
  .bready     (bready),
  .read_done  (read_done),
  .write_done (write_done)
);

`default_nettype wire

/* tb_lsu.sv */
`default_nettype none

module tb_lsu;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_words      = 64;
  localparam int latency        = 2;
  localparam int reset_cycles   = 16;
  localparam int num_random     = 400;
  localparam int num_accesses   = mem_words + 1 + num_random;
  localparam int timeout_cycles = 40 * num_accesses;

  // Access size codes on the size port.
  localparam logic [1:0] code_byte = 2'd0;
  localparam logic [1:0] code_half = 2'd1;
  localparam logic [1:0] code_word = 2'd2;

  logic        clock;
  logic        reset;
  logic        ren;
  logic        wen;
  logic [31:0] addr;
  logic [1:0]  size_sel;
  logic        sext;
  logic [31:0] wsrc;
  logic [31:0] mem_rdata;
  logic        read_done;
  logic        write_done;

  logic [31:0] model [mem_words];
  int          cycle_count;
  logic        fail_reported;
  logic        run_passed;

  lsu_subsystem #(
    .mem_words (mem_words),
    .latency   (latency)
  ) u_lsu_subsystem (
    .clock      (clock),
    .reset      (reset),
    .ren        (ren),
    .wen        (wen),
    .addr       (addr),
    .size       (lsu_pkg::size_t'(size_sel)),
    .sext       (sext),
    .wsrc       (wsrc),
    .mem_rdata  (mem_rdata),
    .read_done  (read_done),
    .write_done (write_done)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string what);
    fail_reported = 1'b1;
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("ERROR: %s is 0x%08h, expected 0x%08h",
                                  name, actual, expected));
    end
  endtask

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      stop_with_failure($sformatf("Timeout after %0d cycles", cycle_count));
    end
  end

  final begin
    if (!run_passed && !fail_reported) begin
      $display("Regression failed");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] expected_load(input logic [31:0] word, input int offset,
                                                input logic [1:0] size_code, input logic sign);
    logic [7:0]  bytes [4];
    logic [7:0]  b;
    logic [15:0] h;
    for (int i = 0; i < 4; i++) begin
      bytes[i] = word[8*i +: 8];
    end
    b = bytes[offset];
    h = {bytes[(offset + 1) % 4], bytes[offset]};
    case (size_code)
      code_byte: return sign ? {{24{b[7]}}, b} : {24'h0, b};
      code_half: return sign ? {{16{h[15]}}, h} : {16'h0, h};
      default:   return word;
    endcase
  endfunction

  task automatic apply_store(input int index, input int offset, input logic [1:0] size_code,
                             input logic [31:0] data);
    case (size_code)
      code_byte: model[index][8*offset +: 8] = data[7:0];
      code_half: model[index][8*offset +: 16] = data[15:0];
      default:   model[index] = data;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // One access, from strobe to done pulse
  //////////////////////////////////////////////////////////////////////

  task automatic do_access(input logic is_store, input int index, input int offset,
                           input logic [1:0] size_code, input logic sign,
                           input logic [31:0] data, input logic extra_strobe);
    logic [31:0] expected;
    expected = expected_load(model[index], offset, size_code, sign);
    @(posedge clock);
    #10;
    addr     = 32'(index * 4 + offset);
    size_sel = size_code;
    sext     = sign;
    wsrc     = data;
    wen      = is_store;
    ren      = !is_store;
    @(posedge clock);
    #10;
    ren = 1'b0;
    wen = 1'b0;
    // A second strobe while the access is in flight.
    if (extra_strobe) begin
      @(posedge clock);
      #10;
      ren = 1'b1;
      @(posedge clock);
      #10;
      ren = 1'b0;
    end
    @(negedge clock);
    while (!(read_done || write_done)) begin
      @(negedge clock);
    end
    if (is_store && read_done) begin
      stop_with_failure("A store ended with a read_done pulse");
    end
    if (!is_store && write_done) begin
      stop_with_failure("A load ended with a write_done pulse");
    end
    if (is_store) begin
      apply_store(index, offset, size_code, data);
    end else begin
      check_value("mem_rdata", mem_rdata, expected);
    end
    @(negedge clock);
    if (read_done || write_done) begin
      stop_with_failure("A done pulse lasted more than one cycle");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          index;
    int          offset;
    logic [1:0]  size_code;
    logic        is_store;
    logic        sign;
    logic [31:0] data;
    void'($urandom(89631));
    cycle_count   = 0;
    fail_reported = 1'b0;
    run_passed    = 1'b0;
    reset         = 1'b1;
    ren           = 1'b0;
    wen           = 1'b0;
    addr          = 32'h0;
    size_sel      = code_word;
    sext          = 1'b0;
    wsrc          = 32'h0;
    repeat (reset_cycles) @(posedge clock);
    #10;
    reset = 1'b0;

    // No done pulse before the first strobe.
    repeat (4) begin
      @(negedge clock);
      if (read_done || write_done) begin
        stop_with_failure("A done pulse appeared after reset before any strobe");
      end
    end

    // Fill memory and model with the same random words.
    for (int i = 0; i < mem_words; i++) begin
      data = $urandom;
      do_access(1'b1, i, 0, code_word, 1'b0, data, 1'b0);
    end

    index = int'($urandom % mem_words);
    do_access(1'b0, index, 0, code_word, 1'b0, 32'h0, 1'b1);
    repeat (12) begin
      @(negedge clock);
      if (read_done || write_done) begin
        stop_with_failure("A strobe during a load started a second access");
      end
    end

    for (int n = 0; n < num_random; n++) begin
      index     = int'($urandom % mem_words);
      size_code = 2'($urandom % 3);
      is_store  = 1'($urandom % 2);
      sign      = 1'($urandom % 2);
      data      = $urandom;
      case (size_code)
        code_byte: offset = int'($urandom % 4);
        code_half: offset = int'($urandom % 2) * 2;
        default:   offset = 0;
      endcase
      do_access(is_store, index, offset, size_code, sign, data, 1'b0);
    end

    run_passed = 1'b1;
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
lsu_pkg.sv
lsu_lane_steer.sv
lsu_axi.sv
axi_lite_ram.sv
lsu_subsystem.sv
lsu_chk.sv
tb_lsu.sv

/* Makefile */
LOG = sim.log

.PHONY: all lint sim clean

all: lint sim

lint:
	verilator --lint-only --top-module lsu_subsystem lsu_pkg.sv lsu_lane_steer.sv \
		lsu_axi.sv axi_lite_ram.sv lsu_subsystem.sv

sim:
	verilator --binary --timing --assert --top-module tb_lsu -f sources.f -o tb_lsu
	-./obj_dir/tb_lsu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
